// ==== fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// address and instruction width
`define XLEN            32

// direct-mapped icache geometry, 8-byte blocks of two words
`define ICACHE_LINES    32
`define ICACHE_IDX_W    5
`define BLOCK_OFS_W     3

// memory tags, tag 0 reserved for "no tag"
`define NUM_MEM_TAGS    16
`define MEM_TAG_W       4

// miss table limit and its counter width
`define MAX_OUTSTANDING 4
`define MISS_CNT_W      3

// instruction buffer
`define IBUFF_DEPTH     8
`define IBUFF_PTR_W     3
`define IBUFF_CNT_W     4

// instructions written or read per cycle
`define FETCH_WIDTH     2

`endif

// ==== fetch_pkg.sv ====
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

    // byte address
    typedef logic [`XLEN-1:0] addr_t;

    // one cache block, word0 sits at block offset 0
    typedef struct packed {
        logic [31:0] word1;
        logic [31:0] word0;
    } mem_block_t;

    // memory transaction tag, zero means none
    typedef logic [`MEM_TAG_W-1:0] mem_tag_t;

    // one fetched instruction as handed to dispatch
    typedef struct packed {
        logic [31:0] inst;
        addr_t       pc;
        addr_t       npc;
        logic        pred_taken;
    } inst_packet_t;

    typedef enum logic [1:0] {
        MEM_NONE = 2'b00,
        MEM_LOAD = 2'b01
    } mem_cmd_e;

    typedef enum logic [1:0] {
        FETCH_RUN  = 2'b00,
        FETCH_MISS = 2'b01,
        FETCH_FULL = 2'b10
    } fetch_state_e;

    // request from fetch to memory
    typedef struct packed {
        mem_cmd_e cmd;
        addr_t    addr;
    } mem_req_t;

    // returning data bus, valid while data_tag is nonzero
    typedef struct packed {
        mem_tag_t   data_tag;
        mem_block_t data;
    } mem_resp_t;

endpackage

`default_nettype wire

// ==== icache.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module icache (
    input  logic                  clock,
    input  logic                  rst_n,
    input  fetch_pkg::addr_t      lookup_addr,
    input  fetch_pkg::addr_t      probe_addr,
    input  logic                  fill_en,
    input  fetch_pkg::addr_t      fill_addr,
    input  fetch_pkg::mem_block_t fill_data,
    output logic                  cache_hit,
    output fetch_pkg::mem_block_t cache_block,
    output logic                  next_line_valid
);
    import fetch_pkg::*;

    localparam int TAG_W = `XLEN - `ICACHE_IDX_W - `BLOCK_OFS_W;

    logic [`ICACHE_LINES-1:0] valid;
    logic [TAG_W-1:0]         tags [`ICACHE_LINES];
    mem_block_t               data [`ICACHE_LINES];

    logic [`ICACHE_IDX_W-1:0] lookup_idx;
    logic [`ICACHE_IDX_W-1:0] probe_idx;
    logic [`ICACHE_IDX_W-1:0] fill_idx;
    logic [TAG_W-1:0]         lookup_tag;
    logic [TAG_W-1:0]         probe_tag;
    logic [TAG_W-1:0]         fill_tag;

    // split addresses into index above the block offset and tag above that
    assign lookup_idx = lookup_addr[`BLOCK_OFS_W +: `ICACHE_IDX_W];
    assign probe_idx  = probe_addr[`BLOCK_OFS_W +: `ICACHE_IDX_W];
    assign fill_idx   = fill_addr[`BLOCK_OFS_W +: `ICACHE_IDX_W];
    assign lookup_tag = lookup_addr[`XLEN-1 -: TAG_W];
    assign probe_tag  = probe_addr[`XLEN-1 -: TAG_W];
    assign fill_tag   = fill_addr[`XLEN-1 -: TAG_W];

    // fetch read port
    assign cache_hit   = valid[lookup_idx] && (tags[lookup_idx] == lookup_tag);
    assign cache_block = data[lookup_idx];

    // prefetch probe, tag check only
    assign next_line_valid = valid[probe_idx] && (tags[probe_idx] == probe_tag);

    // valid bits start clear so the cache comes up empty
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    // fill lands at the edge, the hit shows one cycle later
    always_ff @(posedge clock) begin
        if (fill_en) begin
            tags[fill_idx] <= fill_tag;
            data[fill_idx] <= fill_data;
        end
    end

endmodule

`default_nettype wire

// ==== miss_table.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module miss_table (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  alloc_en,
    input  fetch_pkg::mem_tag_t   alloc_tag,
    input  fetch_pkg::addr_t      alloc_addr,
    input  fetch_pkg::mem_resp_t  mem_resp,
    input  fetch_pkg::addr_t      lookup_addr,
    input  fetch_pkg::addr_t      probe_addr,
    output logic                  fill_en,
    output fetch_pkg::addr_t      fill_addr,
    output fetch_pkg::mem_block_t fill_data,
    output logic                  line_pending,
    output logic                  next_pending,
    output logic                  table_full
);
    localparam int LINE_W = `XLEN - `BLOCK_OFS_W;

    // one entry per memory tag, entry 0 never allocated
    logic [`NUM_MEM_TAGS-1:0] valid;
    logic [LINE_W-1:0]        line [`NUM_MEM_TAGS];
    logic [`MISS_CNT_W-1:0]   count;

    // returning data matches an outstanding entry
    assign fill_en   = (mem_resp.data_tag != '0) && valid[mem_resp.data_tag];
    assign fill_addr = {line[mem_resp.data_tag], {`BLOCK_OFS_W{1'b0}}};
    assign fill_data = mem_resp.data;

    assign table_full = (count >= `MISS_CNT_W'(`MAX_OUTSTANDING));

    // block address compare against every live entry
    always_comb begin
        line_pending = 1'b0;
        next_pending = 1'b0;
        for (int i = 1; i < `NUM_MEM_TAGS; i++) begin
            if (valid[i] && (line[i] == lookup_addr[`XLEN-1:`BLOCK_OFS_W])) begin
                line_pending = 1'b1;
            end
            if (valid[i] && (line[i] == probe_addr[`XLEN-1:`BLOCK_OFS_W])) begin
                next_pending = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
            count <= '0;
        end else begin
            // free first, a new allocation may reuse the same tag
            if (fill_en) begin
                valid[mem_resp.data_tag] <= 1'b0;
            end
            if (alloc_en) begin
                valid[alloc_tag] <= 1'b1;
            end
            case ({alloc_en, fill_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // address of each outstanding block
    always_ff @(posedge clock) begin
        if (alloc_en) begin
            line[alloc_tag] <= alloc_addr[`XLEN-1:`BLOCK_OFS_W];
        end
    end

endmodule

`default_nettype wire

// ==== fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module fetch (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    br_en,
    input  fetch_pkg::addr_t        target,
    input  logic                    cache_hit,
    input  fetch_pkg::mem_block_t   cache_block,
    input  logic                    next_line_valid,
    input  logic                    line_pending,
    input  logic                    next_pending,
    input  logic                    table_full,
    input  logic                    fill_en,
    input  logic [3:0]              free_slots,
    input  fetch_pkg::mem_tag_t     mem_accept_tag,
    output fetch_pkg::addr_t        lookup_addr,
    output fetch_pkg::addr_t        probe_addr,
    output fetch_pkg::mem_req_t     mem_req,
    output logic                    alloc_en,
    output fetch_pkg::mem_tag_t     alloc_tag,
    output fetch_pkg::addr_t        alloc_addr,
    output fetch_pkg::inst_packet_t [`FETCH_WIDTH-1:0] wr_pkts,
    output logic [1:0]              wr_count
);
    import fetch_pkg::*;

    fetch_state_e state;
    fetch_state_e next_state;
    addr_t        pc;
    addr_t        line_addr;
    addr_t        next_addr;
    logic [1:0]   avail;
    logic [1:0]   n_write;
    logic         need_line;
    logic         need_next;

    // current block and the sequential one after it
    assign line_addr   = {pc[`XLEN-1:`BLOCK_OFS_W], {`BLOCK_OFS_W{1'b0}}};
    assign next_addr   = line_addr + (addr_t'(1) << `BLOCK_OFS_W);
    assign lookup_addr = pc;
    assign probe_addr  = next_addr;

    // words left in the block from pc, capped by buffer room
    assign avail   = pc[`BLOCK_OFS_W-1] ? 2'd1 : 2'd2;
    assign n_write = (free_slots < {2'b00, avail}) ? free_slots[1:0] : avail;
    assign wr_count = cache_hit ? n_write : 2'd0;

    // packets straight from the cache block, predicted not taken
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            addr_t slot_pc;
            slot_pc = pc + addr_t'(4 * i);
            wr_pkts[i].pc         = slot_pc;
            wr_pkts[i].inst       = slot_pc[`BLOCK_OFS_W-1] ? cache_block.word1
                                                            : cache_block.word0;
            wr_pkts[i].npc        = slot_pc + addr_t'(4);
            wr_pkts[i].pred_taken = 1'b0;
        end
    end

    // memory requests, demand line ahead of prefetch
    assign need_line = !cache_hit && !line_pending;
    assign need_next = !next_line_valid && !next_pending;

    always_comb begin
        mem_req.cmd  = MEM_NONE;
        mem_req.addr = line_addr;
        if (!table_full) begin
            if (need_line) begin
                mem_req.cmd  = MEM_LOAD;
                mem_req.addr = line_addr;
            end else if (need_next) begin
                mem_req.cmd  = MEM_LOAD;
                mem_req.addr = next_addr;
            end
        end
    end

    // a nonzero tag back from memory means the load was taken
    assign alloc_en   = (mem_req.cmd == MEM_LOAD) && (mem_accept_tag != '0);
    assign alloc_tag  = mem_accept_tag;
    assign alloc_addr = mem_req.addr;

    always_comb begin
        next_state = state;
        case (state)
            FETCH_RUN: begin
                if (!cache_hit) begin
                    next_state = (table_full && !line_pending) ? FETCH_FULL : FETCH_MISS;
                end
            end
            FETCH_MISS: begin
                // any fill may be our line, recheck in run
                if (cache_hit || fill_en) begin
                    next_state = FETCH_RUN;
                end else if (table_full && !line_pending) begin
                    next_state = FETCH_FULL;
                end
            end
            FETCH_FULL: begin
                if (cache_hit) begin
                    next_state = FETCH_RUN;
                end else if (!table_full) begin
                    next_state = FETCH_MISS;
                end
            end
            default: next_state = FETCH_RUN;
        endcase
    end

    // redirect wins over the sequential advance
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '0;
            state <= FETCH_RUN;
        end else if (br_en) begin
            pc    <= target;
            state <= FETCH_RUN;
        end else begin
            pc    <= pc + addr_t'({wr_count, 2'b00});
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

// ==== inst_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module inst_buffer (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    br_en,
    input  fetch_pkg::inst_packet_t [`FETCH_WIDTH-1:0] wr_pkts,
    input  logic [1:0]              wr_count,
    input  logic [1:0]              dispatch_take,
    output fetch_pkg::inst_packet_t [`FETCH_WIDTH-1:0] out_insts,
    output logic [1:0]              out_count,
    output logic [3:0]              free_slots
);
    import fetch_pkg::*;

    localparam int PTR_W = `IBUFF_PTR_W;
    localparam int CNT_W = `IBUFF_CNT_W;
    localparam logic [3:0] DEPTH_CNT = `IBUFF_DEPTH;

    inst_packet_t     slots [`IBUFF_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] occ;
    logic [1:0]       pop_count;

    // oldest entries first, slot 1 may be stale when out_count is 1
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            out_insts[i] = slots[head + PTR_W'(i)];
        end
    end

    assign out_count  = (occ >= CNT_W'(2)) ? 2'd2 : occ[1:0];
    assign free_slots = DEPTH_CNT - 4'(occ);

    // dispatch cannot take more than is shown
    assign pop_count = (dispatch_take > out_count) ? out_count : dispatch_take;

    // pop then push; fetch never writes past free_slots
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
            occ  <= '0;
        end else if (br_en) begin
            // flush, incoming packets are from the old path
            head <= '0;
            tail <= '0;
            occ  <= '0;
        end else begin
            head <= head + PTR_W'(pop_count);
            tail <= tail + PTR_W'(wr_count);
            occ  <= occ - CNT_W'(pop_count) + CNT_W'(wr_count);
        end
    end

    always_ff @(posedge clock) begin
        if (!br_en) begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (2'(i) < wr_count) begin
                    slots[tail + PTR_W'(i)] <= wr_pkts[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== fetch_subsys.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module fetch_subsys (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    br_en,
    input  fetch_pkg::addr_t        target,
    input  fetch_pkg::mem_tag_t     mem_accept_tag,
    input  fetch_pkg::mem_resp_t    mem_resp,
    input  logic [1:0]              dispatch_take,
    output fetch_pkg::mem_req_t     mem_req,
    output fetch_pkg::inst_packet_t [`FETCH_WIDTH-1:0] out_insts,
    output logic [1:0]              out_count
);
    import fetch_pkg::*;

    // fetch to cache and miss table
    addr_t      lookup_addr;
    addr_t      probe_addr;
    logic       cache_hit;
    mem_block_t cache_block;
    logic       next_line_valid;
    logic       alloc_en;
    mem_tag_t   alloc_tag;
    addr_t      alloc_addr;

    // miss table fill path and status
    logic       fill_en;
    addr_t      fill_addr;
    mem_block_t fill_data;
    logic       line_pending;
    logic       next_pending;
    logic       table_full;

    // fetch to buffer
    inst_packet_t [`FETCH_WIDTH-1:0] wr_pkts;
    logic [1:0]                      wr_count;
    logic [3:0]                      free_slots;

    fetch u_fetch (
        .clock(clock), .rst_n(rst_n), .br_en(br_en), .target(target),
        .cache_hit(cache_hit), .cache_block(cache_block), .next_line_valid(next_line_valid),
        .line_pending(line_pending), .next_pending(next_pending), .table_full(table_full),
        .fill_en(fill_en), .free_slots(free_slots), .mem_accept_tag(mem_accept_tag),
        .lookup_addr(lookup_addr), .probe_addr(probe_addr), .mem_req(mem_req),
        .alloc_en(alloc_en), .alloc_tag(alloc_tag), .alloc_addr(alloc_addr),
        .wr_pkts(wr_pkts), .wr_count(wr_count)
    );

    icache u_icache (
        .clock(clock), .rst_n(rst_n), .lookup_addr(lookup_addr), .probe_addr(probe_addr),
        .fill_en(fill_en), .fill_addr(fill_addr), .fill_data(fill_data),
        .cache_hit(cache_hit), .cache_block(cache_block), .next_line_valid(next_line_valid)
    );

    miss_table u_miss_table (
        .clock(clock), .rst_n(rst_n), .alloc_en(alloc_en), .alloc_tag(alloc_tag),
        .alloc_addr(alloc_addr), .mem_resp(mem_resp), .lookup_addr(lookup_addr),
        .probe_addr(probe_addr), .fill_en(fill_en), .fill_addr(fill_addr),
        .fill_data(fill_data), .line_pending(line_pending), .next_pending(next_pending),
        .table_full(table_full)
    );

    // redirect flushes the buffer in the same edge that moves the pc
    inst_buffer u_inst_buffer (
        .clock(clock), .rst_n(rst_n), .br_en(br_en), .wr_pkts(wr_pkts),
        .wr_count(wr_count), .dispatch_take(dispatch_take), .out_insts(out_insts),
        .out_count(out_count), .free_slots(free_slots)
    );

endmodule

`default_nettype wire

// ==== fetch_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module fetch_mem_model (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 reject_en,
    input  fetch_pkg::mem_req_t  mem_req,
    output fetch_pkg::mem_tag_t  mem_accept_tag,
    output fetch_pkg::mem_resp_t mem_resp
);
    import fetch_pkg::*;

    localparam int          LATENCY  = 6;
    localparam logic [31:0] WORD_KEY = 32'h5a5a0000;

    integer   seed = 32'hbcb0;
    logic     reject_now;
    mem_tag_t next_tag;
    mem_tag_t pipe_tag  [LATENCY];
    addr_t    pipe_addr [LATENCY];

    // memory contents follow from the address alone
    function automatic logic [31:0] word_at(input addr_t a);
        return a ^ WORD_KEY;
    endfunction

    // accept in the same cycle unless this draw says reject
    always_comb begin
        mem_accept_tag = '0;
        if ((mem_req.cmd == MEM_LOAD) && !(reject_en && reject_now)) begin
            mem_accept_tag = next_tag;
        end
    end

    // oldest stage of the delay line drives the data bus
    assign mem_resp.data_tag   = pipe_tag[LATENCY-1];
    assign mem_resp.data.word0 = word_at(pipe_addr[LATENCY-1]);
    assign mem_resp.data.word1 = word_at(pipe_addr[LATENCY-1] + 32'd4);

    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            next_tag   <= mem_tag_t'(1);
            reject_now <= 1'b0;
            for (int i = 0; i < LATENCY; i++) begin
                pipe_tag[i] <= '0;
            end
        end else begin
            // roughly one cycle in four refuses a load
            reject_now <= (($random(seed) & 3) == 0);
            // tags 1..15 in turn, zero is never handed out
            if (mem_accept_tag != '0) begin
                next_tag <= (next_tag == mem_tag_t'(`NUM_MEM_TAGS - 1)) ? mem_tag_t'(1)
                                                                       : next_tag + 1'b1;
            end
            pipe_tag[0]  <= mem_accept_tag;
            pipe_addr[0] <= mem_req.addr;
            for (int i = 1; i < LATENCY; i++) begin
                pipe_tag[i]  <= pipe_tag[i-1];
                pipe_addr[i] <= pipe_addr[i-1];
            end
        end
    end

endmodule

`default_nettype wire

// ==== fetch_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module fetch_tb;
    import fetch_pkg::*;

    // six tests of a few hundred cycles each, with margin
    localparam int MAX_CYCLES = 4000;

    logic                            clock;
    logic                            rst_n;
    logic                            br_en;
    addr_t                           target;
    logic [1:0]                      dispatch_take;
    logic                            reject_en;
    mem_tag_t                        mem_accept_tag;
    mem_resp_t                       mem_resp;
    mem_req_t                        mem_req;
    inst_packet_t [`FETCH_WIDTH-1:0] out_insts;
    logic [1:0]                      out_count;

    int    cycle_count;
    logic  monitor_en;
    addr_t load_log [$];

    fetch_subsys uut (
        .clock(clock), .rst_n(rst_n), .br_en(br_en), .target(target),
        .mem_accept_tag(mem_accept_tag), .mem_resp(mem_resp),
        .dispatch_take(dispatch_take), .mem_req(mem_req),
        .out_insts(out_insts), .out_count(out_count)
    );

    fetch_mem_model u_mem (
        .clock(clock), .rst_n(rst_n), .reject_en(reject_en), .mem_req(mem_req),
        .mem_accept_tag(mem_accept_tag), .mem_resp(mem_resp)
    );

    always #20 clock = ~clock;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    // cycle limit
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            fail_run("timeout, the tests did not finish within the cycle limit");
        end
    end

    // record every load the fetch stage puts on the bus
    always @(posedge clock) begin
        if (monitor_en && (mem_req.cmd == MEM_LOAD)) begin
            load_log.push_back(mem_req.addr);
        end
    end

    task automatic check_pkt(input string name, input inst_packet_t got, input inst_packet_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    // expected packet, built from the memory pattern and not-taken prediction
    function automatic inst_packet_t expect_pkt(input addr_t pc);
        inst_packet_t pkt;
        pkt.inst       = pc ^ 32'h5a5a0000;
        pkt.pc         = pc;
        pkt.npc        = pc + 32'd4;
        pkt.pred_taken = 1'b0;
        return pkt;
    endfunction

    // one-cycle pulse, buffer must be empty at the next falling edge
    task automatic redirect(input addr_t dest);
        @(negedge clock);
        br_en         = 1'b1;
        target        = dest;
        dispatch_take = 2'd0;
        @(negedge clock);
        br_en = 1'b0;
        check_count("out_count", out_count, 2'd0);
    endtask

    task automatic wait_for_count(input logic [1:0] n);
        while (out_count < n) begin
            @(negedge clock);
        end
    endtask

    // pop n packets and check they run on from start with no gap
    task automatic drain_expect(input addr_t start, input int n);
        addr_t exp_pc;
        int    got;
        int    take;
        exp_pc = start;
        got    = 0;
        while (got < n) begin
            take = int'(out_count);
            if (take > n - got) begin
                take = n - got;
            end
            for (int i = 0; i < take; i++) begin
                check_pkt($sformatf("out_insts[%0d]", i), out_insts[i], expect_pkt(exp_pc));
                exp_pc = exp_pc + 32'd4;
            end
            dispatch_take = 2'(take);
            got           = got + take;
            @(negedge clock);
        end
        dispatch_take = 2'd0;
    endtask

    task automatic sequential_stream();
        reject_en = 1'b0;
        redirect(32'h40);
        drain_expect(32'h40, 24);
    endtask

    // 0x40..0x9f is now cached, a second pass must not load it
    task automatic cached_refetch();
        load_log.delete();
        monitor_en = 1'b1;
        redirect(32'h40);
        drain_expect(32'h40, 24);
        monitor_en = 1'b0;
        foreach (load_log[i]) begin
            if ((load_log[i] >= 32'h40) && (load_log[i] < 32'ha0)) begin
                fail_run($sformatf("load sent for cached line at address %h", load_log[i]));
            end
        end
    endtask

    task automatic mid_stream_redirect();
        redirect(32'h40);
        drain_expect(32'h40, 4);
        wait_for_count(2'd2);
        redirect(32'h90);
        drain_expect(32'h90, 8);
    endtask

    // second word of a block yields a single packet first
    task automatic odd_start();
        redirect(32'h44);
        wait_for_count(2'd1);
        check_count("out_count", out_count, 2'd1);
        check_addr("out_insts[0].pc", out_insts[0].pc, 32'h44);
        drain_expect(32'h44, 6);
    endtask

    task automatic back_pressure();
        redirect(32'ha0);
        wait_for_count(2'd2);
        repeat (30) begin
            @(negedge clock);
            check_count("out_count", out_count, 2'd2);
        end
        drain_expect(32'ha0, 16);
    endtask

    // fresh region so the loads really reach memory
    task automatic rejected_loads();
        reject_en = 1'b1;
        redirect(32'h400);
        drain_expect(32'h400, 24);
        reject_en = 1'b0;
    endtask

    initial begin
        clock         = 1'b0;
        rst_n         = 1'b0;
        br_en         = 1'b0;
        target        = '0;
        dispatch_take = 2'd0;
        reject_en     = 1'b0;
        monitor_en    = 1'b0;
        cycle_count   = 0;
        repeat (2) @(negedge clock);
        rst_n = 1'b1;
        sequential_stream();
        cached_refetch();
        mid_stream_redirect();
        odd_start();
        back_pressure();
        rejected_loads();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch_subsys.f ====
+incdir+.
fetch_pkg.sv
icache.sv
miss_table.sv
fetch.sv
inst_buffer.sv
fetch_subsys.sv
fetch_mem_model.sv
fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := fetch_tb
FILELIST  := fetch_subsys.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv) $(wildcard *.svh) $(FILELIST)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
